// ==== common/soc_addr_pkg.sv ====
/*
 * Cluster address map
 * Base addresses and sizes of every region, the word offset widths that
 * follow from them, and the region type used by the bus decoder.
 */
package soc_addr_pkg;

  localparam int unsigned AddrWidth = 32;

  // Region map, all bases aligned to their size
  localparam logic [AddrWidth-1:0] BootromBase  = 32'h0000_0000;
  localparam int unsigned          BootromSize  = 64;
  localparam logic [AddrWidth-1:0] InstrMemBase = 32'h0001_0000;
  localparam int unsigned          InstrMemSize = 1024;
  localparam logic [AddrWidth-1:0] DataMemBase  = 32'h0002_0000;
  localparam int unsigned          DataMemSize  = 1024;
  localparam logic [AddrWidth-1:0] CsrBase      = 32'h0003_0000;
  localparam int unsigned          CsrSize      = 16;

  // Word offset widths
  localparam int unsigned InstrMemAddrWidth = $clog2(InstrMemSize / 4);
  localparam int unsigned DataMemAddrWidth  = $clog2(DataMemSize / 4);
  localparam int unsigned BootromAddrWidth  = $clog2(BootromSize / 4);
  localparam int unsigned CsrAddrWidth      = $clog2(CsrSize / 4);

  // CSR register indices
  localparam logic [CsrAddrWidth-1:0] CsrRegEoc     = 2'd0;
  localparam logic [CsrAddrWidth-1:0] CsrRegScratch = 2'd1;
  localparam logic [CsrAddrWidth-1:0] CsrRegId      = 2'd2;

  localparam logic [31:0] ClusterId = 32'hC105_7E01;

  typedef enum logic [1:0] {
    RegionNone  = 2'd0,
    RegionInstr = 2'd1,
    RegionData  = 2'd2,
    RegionCsr   = 2'd3
  } region_e;

  // True when addr falls inside a size-aligned region
  function automatic logic in_region(input logic [AddrWidth-1:0] addr,
                                     input logic [AddrWidth-1:0] base,
                                     input int unsigned size);
    logic [AddrWidth-1:0] mask;
    mask = ~(AddrWidth'(size - 1));
    return (addr & mask) == base;
  endfunction

endpackage

// ==== common/soc_bus_pkg.sv ====
/*
 * Cluster bus types
 * Request and response words of the external bus and the request word
 * handed to each memory target, plus the byte strobe merge.
 */
package soc_bus_pkg;

  import soc_addr_pkg::*;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // External bus request, 69 bits
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] strb;
  } bus_req_t;

  // External bus response, 33 bits
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

  // Request to a target after remapping, 45 bits
  typedef struct packed {
    logic [InstrMemAddrWidth-1:0] off;
    logic                         we;
    logic [DataWidth-1:0]         wdata;
    logic [StrbWidth-1:0]         strb;
  } mem_req_t;

  // Replace the bytes of old_word selected by strb
  function automatic logic [DataWidth-1:0] strb_merge(input logic [DataWidth-1:0] old_word,
                                                      input logic [DataWidth-1:0] new_word,
                                                      input logic [StrbWidth-1:0] strb);
    logic [DataWidth-1:0] res;
    res = old_word;
    for (int i = 0; i < StrbWidth; i++) begin
      if (strb[i]) res[8*i +: 8] = new_word[8*i +: 8];
    end
    return res;
  endfunction

endpackage

// ==== rtl/mem/instr_mem.sv ====
/*
 * Instruction memory
 * One synchronous read port shared by fetch and bus with fetch first,
 * and a separate byte-strobed write port for the bus.
 */
module instr_mem
  import soc_addr_pkg::*;
  import soc_bus_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         fetch_rd_i,
  input  logic [InstrMemAddrWidth-1:0] fetch_addr_i,
  input  logic                         bus_rd_i,
  input  mem_req_t                     bus_req_i,
  input  logic                         bus_we_i,
  output logic                         bus_rd_gnt_o,
  output logic [DataWidth-1:0]         rdata_o
);

  localparam int unsigned Depth = 2 ** InstrMemAddrWidth;

  logic [DataWidth-1:0]         mem [Depth];
  logic                         rd_en;
  logic [InstrMemAddrWidth-1:0] rd_addr;

  // Fixed priority to fetch on the read port
  assign bus_rd_gnt_o = !(fetch_rd_i && bus_rd_i);
  assign rd_en        = fetch_rd_i || bus_rd_i;
  assign rd_addr      = fetch_rd_i ? fetch_addr_i : bus_req_i.off;

  // Read and write of one word in a cycle gives the old word
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_o <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_we_i) begin
      mem[bus_req_i.off] <= strb_merge(mem[bus_req_i.off], bus_req_i.wdata, bus_req_i.strb);
    end
  end

  // A bus read that loses the port finds it free in the next cycle
  bus_read_not_starved: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (bus_rd_i && !bus_rd_gnt_o) |=> !fetch_rd_i
  ) else $error("fetch reads in consecutive cycles starve the bus read");

endmodule

// ==== rtl/mem/data_mem.sv ====
/*
 * Data memory
 * Byte-strobed writes and registered reads under one enable.
 */
module data_mem
  import soc_addr_pkg::*;
  import soc_bus_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 en_i,
  input  mem_req_t             req_i,
  output logic [DataWidth-1:0] rdata_o
);

  localparam int unsigned Depth = 2 ** DataMemAddrWidth;

  logic [DataWidth-1:0]        mem [Depth];
  logic [DataMemAddrWidth-1:0] addr;

  assign addr = req_i.off[DataMemAddrWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      rdata_o <= mem[addr];
      if (req_i.we) begin
        mem[addr] <= strb_merge(mem[addr], req_i.wdata, req_i.strb);
      end
    end
  end

endmodule

// ==== rtl/cluster_csrs.sv ====
/*
 * Cluster control registers
 * End of computation, a scratch word, the cluster ID and one
 * reserved slot that reads zero.
 */
module cluster_csrs
  import soc_addr_pkg::*;
  import soc_bus_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 en_i,
  input  mem_req_t             req_i,
  output logic [DataWidth-1:0] rdata_o,
  output logic [DataWidth-1:0] eoc_o
);

  logic [CsrAddrWidth-1:0] reg_idx;
  logic [DataWidth-1:0]    eoc_q;
  logic [DataWidth-1:0]    scratch_q;

  assign reg_idx = req_i.off[CsrAddrWidth-1:0];

  // Writes to the ID and reserved slots are dropped
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      eoc_q     <= '0;
      scratch_q <= '0;
    end else if (en_i && req_i.we) begin
      case (reg_idx)
        CsrRegEoc:     eoc_q     <= strb_merge(eoc_q, req_i.wdata, req_i.strb);
        CsrRegScratch: scratch_q <= strb_merge(scratch_q, req_i.wdata, req_i.strb);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      case (reg_idx)
        CsrRegEoc:     rdata_o <= eoc_q;
        CsrRegScratch: rdata_o <= scratch_q;
        CsrRegId:      rdata_o <= ClusterId;
        default:       rdata_o <= '0;
      endcase
    end
  end

  assign eoc_o = eoc_q;

endmodule

// ==== rtl/fetch_router.sv ====
/*
 * Fetch router
 * Serves fetches from the boot ROM table in the same cycle, or issues a
 * single read to the instruction memory and answers it one cycle later.
 */
module fetch_router
  import soc_addr_pkg::*;
  import soc_bus_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         fetch_valid_i,
  input  logic [AddrWidth-1:0]         fetch_addr_i,
  output logic                         fetch_ready_o,
  output logic [DataWidth-1:0]         fetch_data_o,
  output logic                         imem_rd_o,
  output logic [InstrMemAddrWidth-1:0] imem_addr_o,
  input  logic [DataWidth-1:0]         imem_rdata_i
);

  logic is_rom;
  logic is_imem;
  logic pending_q;

  // Boot code jumps to the start of the instruction memory
  function automatic logic [DataWidth-1:0] rom_word(input logic [BootromAddrWidth-1:0] idx);
    case (idx)
      4'd0:    return 32'h0001_02B7; // lui  t0, 0x10
      4'd1:    return 32'h0000_0313; // li   t1, 0
      4'd2:    return 32'h0003_0393; // mv   t2, t1
      4'd3:    return 32'h0002_8067; // jr   t0
      4'd14:   return 32'h1050_0073; // wfi
      4'd15:   return 32'h0000_006F; // j    .
      default: return 32'h0000_0013; // nop
    endcase
  endfunction

  assign is_rom  = in_region(fetch_addr_i, BootromBase, BootromSize);
  assign is_imem = in_region(fetch_addr_i, InstrMemBase, InstrMemSize);

  // One read per fetch, held off while its data is on the way
  assign imem_rd_o   = fetch_valid_i && is_imem && !pending_q;
  assign imem_addr_o = fetch_addr_i[InstrMemAddrWidth+1:2];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= imem_rd_o;
    end
  end

  assign fetch_ready_o = pending_q || (fetch_valid_i && is_rom);
  assign fetch_data_o  = pending_q ? imem_rdata_i
                                   : rom_word(fetch_addr_i[BootromAddrWidth+1:2]);

  fetch_addr_legal: assert property (
    @(posedge clk_i) disable iff (rst_i)
    fetch_valid_i |-> (is_rom || is_imem)
  ) else $error("fetch from illegal address 0x%h", fetch_addr_i);

  fetch_addr_held: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (fetch_valid_i && !fetch_ready_o) |=> (fetch_valid_i && $stable(fetch_addr_i))
  ) else $error("fetch request changed before ready");

endmodule

// ==== rtl/bus_decoder.sv ====
/*
 * External bus decoder
 * Finds the target region of each request, remaps it to a word offset,
 * raises one target strobe and returns the response one cycle later.
 */
module bus_decoder
  import soc_addr_pkg::*;
  import soc_bus_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 bus_valid_i,
  input  bus_req_t             bus_req_i,
  output logic                 bus_gnt_o,
  output logic                 bus_rsp_valid_o,
  output bus_rsp_t             bus_rsp_o,
  output mem_req_t             tgt_req_o,
  output logic                 instr_we_o,
  output logic                 instr_rd_o,
  output logic                 data_en_o,
  output logic                 csr_en_o,
  input  logic                 instr_rd_gnt_i,
  input  logic [DataWidth-1:0] instr_rdata_i,
  input  logic [DataWidth-1:0] data_rdata_i,
  input  logic [DataWidth-1:0] csr_rdata_i
);

  region_e              region;
  logic [AddrWidth-1:0] region_mask;
  logic [AddrWidth-1:0] masked_addr;
  logic                 accept;

  logic                 rsp_valid_q;
  region_e              rsp_region_q;
  logic                 rsp_rd_q;
  logic                 rsp_err_q;

  //////////////////////////////////////////////////////////////////////
  // Decode and remap

  // Boot ROM is fetch only, so the bus sees it as unmapped
  always_comb begin
    region      = RegionNone;
    region_mask = '0;
    if (in_region(bus_req_i.addr, InstrMemBase, InstrMemSize)) begin
      region      = RegionInstr;
      region_mask = AddrWidth'(InstrMemSize - 1);
    end else if (in_region(bus_req_i.addr, DataMemBase, DataMemSize)) begin
      region      = RegionData;
      region_mask = AddrWidth'(DataMemSize - 1);
    end else if (in_region(bus_req_i.addr, CsrBase, CsrSize)) begin
      region      = RegionCsr;
      region_mask = AddrWidth'(CsrSize - 1);
    end
  end

  assign masked_addr = bus_req_i.addr & region_mask;

  always_comb begin
    tgt_req_o.off   = masked_addr[InstrMemAddrWidth+1:2];
    tgt_req_o.we    = bus_req_i.we;
    tgt_req_o.wdata = bus_req_i.wdata;
    tgt_req_o.strb  = bus_req_i.strb;
  end

  // Only an instruction memory read can lose against a fetch
  assign instr_rd_o = bus_valid_i && (region == RegionInstr) && !bus_req_i.we;
  assign bus_gnt_o  = !instr_rd_o || instr_rd_gnt_i;
  assign accept     = bus_valid_i && bus_gnt_o;

  assign instr_we_o = accept && (region == RegionInstr) && bus_req_i.we;
  assign data_en_o  = accept && (region == RegionData);
  assign csr_en_o   = accept && (region == RegionCsr);

  //////////////////////////////////////////////////////////////////////
  // Response

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_region_q <= region;
      rsp_rd_q     <= !bus_req_i.we;
      rsp_err_q    <= (region == RegionNone);
    end
  end

  assign bus_rsp_valid_o = rsp_valid_q;

  always_comb begin
    bus_rsp_o.rdata = '0;
    bus_rsp_o.err   = rsp_err_q;
    // Writes and errors answer with zero data
    if (rsp_rd_q) begin
      case (rsp_region_q)
        RegionInstr: bus_rsp_o.rdata = instr_rdata_i;
        RegionData:  bus_rsp_o.rdata = data_rdata_i;
        RegionCsr:   bus_rsp_o.rdata = csr_rdata_i;
        default:     bus_rsp_o.rdata = '0;
      endcase
    end
  end

  single_target_strobe: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $onehot0({instr_we_o, instr_rd_o, data_en_o, csr_en_o})
  ) else $error("more than one target strobe active");

endmodule

// ==== rtl/cluster_top.sv ====
/*
 * Cluster top level
 * Connects the bus decoder, the fetch router and the three targets.
 */
module cluster_top
  import soc_addr_pkg::*;
  import soc_bus_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  // External bus slave port
  input  logic                 bus_valid_i,
  input  bus_req_t             bus_req_i,
  output logic                 bus_gnt_o,
  output logic                 bus_rsp_valid_o,
  output bus_rsp_t             bus_rsp_o,
  // Fetch port
  input  logic                 fetch_valid_i,
  input  logic [AddrWidth-1:0] fetch_addr_i,
  output logic                 fetch_ready_o,
  output logic [DataWidth-1:0] fetch_data_o,
  output logic [DataWidth-1:0] eoc_o
);

  mem_req_t                     tgt_req;
  logic                         instr_we;
  logic                         instr_rd;
  logic                         data_en;
  logic                         csr_en;
  logic                         instr_rd_gnt;
  logic [DataWidth-1:0]         instr_rdata;
  logic [DataWidth-1:0]         data_rdata;
  logic [DataWidth-1:0]         csr_rdata;
  logic                         imem_fetch_rd;
  logic [InstrMemAddrWidth-1:0] imem_fetch_addr;

  //////////////////////////////////////////////////////////////////////
  // Bus side

  bus_decoder i_bus_decoder (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .bus_valid_i    (bus_valid_i),
    .bus_req_i      (bus_req_i),
    .bus_gnt_o      (bus_gnt_o),
    .bus_rsp_valid_o(bus_rsp_valid_o),
    .bus_rsp_o      (bus_rsp_o),
    .tgt_req_o      (tgt_req),
    .instr_we_o     (instr_we),
    .instr_rd_o     (instr_rd),
    .data_en_o      (data_en),
    .csr_en_o       (csr_en),
    .instr_rd_gnt_i (instr_rd_gnt),
    .instr_rdata_i  (instr_rdata),
    .data_rdata_i   (data_rdata),
    .csr_rdata_i    (csr_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Fetch side

  fetch_router i_fetch_router (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .fetch_valid_i(fetch_valid_i),
    .fetch_addr_i (fetch_addr_i),
    .fetch_ready_o(fetch_ready_o),
    .fetch_data_o (fetch_data_o),
    .imem_rd_o    (imem_fetch_rd),
    .imem_addr_o  (imem_fetch_addr),
    .imem_rdata_i (instr_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Targets

  instr_mem i_instr_mem (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fetch_rd_i  (imem_fetch_rd),
    .fetch_addr_i(imem_fetch_addr),
    .bus_rd_i    (instr_rd),
    .bus_req_i   (tgt_req),
    .bus_we_i    (instr_we),
    .bus_rd_gnt_o(instr_rd_gnt),
    .rdata_o     (instr_rdata)
  );

  data_mem i_data_mem (
    .clk_i  (clk_i),
    .en_i   (data_en),
    .req_i  (tgt_req),
    .rdata_o(data_rdata)
  );

  cluster_csrs i_cluster_csrs (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .en_i   (csr_en),
    .req_i  (tgt_req),
    .rdata_o(csr_rdata),
    .eoc_o  (eoc_o)
  );

endmodule

// ==== bench/tb_cluster_top.sv ====
/*
 * Testbench for the cluster top level
 * Plays bus and fetch operations from a cases file against the DUT and
 * compares every response with the expected values listed there.
 */
module tb_cluster_top
  import soc_addr_pkg::*;
  import soc_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          ClkPeriod   = 4;
  localparam int          ResetCycles = 5;
  localparam int          CycleBudget = 20;
  localparam int          CaseWords   = 6;
  localparam int          MaxCases    = 64;
  localparam logic [16:0] LfsrSeed    = 17'd68836;

  // Operation kinds of the cases file
  localparam logic [31:0] KindEnd        = 32'd0;
  localparam logic [31:0] KindWrite      = 32'd1;
  localparam logic [31:0] KindRead       = 32'd2;
  localparam logic [31:0] KindFetch      = 32'd3;
  localparam logic [31:0] KindContention = 32'd4;
  localparam logic [31:0] KindEoc        = 32'd5;

  logic                 clk_i;
  logic                 rst_i;
  logic                 bus_valid_i;
  bus_req_t             bus_req_i;
  logic                 bus_gnt_o;
  logic                 bus_rsp_valid_o;
  bus_rsp_t             bus_rsp_o;
  logic                 fetch_valid_i;
  logic [AddrWidth-1:0] fetch_addr_i;
  logic                 fetch_ready_o;
  logic [DataWidth-1:0] fetch_data_o;
  logic [DataWidth-1:0] eoc_o;

  logic [31:0] cases_mem [CaseWords*MaxCases];
  logic [16:0] lfsr;
  logic        cases_loaded;
  int          errors;
  int          num_cases;

  cluster_top i_cluster_top (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .bus_valid_i    (bus_valid_i),
    .bus_req_i      (bus_req_i),
    .bus_gnt_o      (bus_gnt_o),
    .bus_rsp_valid_o(bus_rsp_valid_o),
    .bus_rsp_o      (bus_rsp_o),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_data_o   (fetch_data_o),
    .eoc_o          (eoc_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Helpers

  // 17-bit Fibonacci LFSR with taps 17 and 14
  function automatic logic [16:0] lfsr_next(input logic [16:0] state);
    return {state[15:0], state[16] ^ state[13]};
  endfunction

  task automatic insert_idle_cycles();
    int gap;
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_next(lfsr);
      gap  = (gap << 1) | int'(lfsr[0]);
    end
    repeat (gap) @(negedge clk_i);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One operation from the cases file

  task automatic run_case(input int idx);
    logic [31:0] kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] strb;
    logic [31:0] exp_val;
    logic [31:0] exp_err;
    logic        bus_done;
    logic        fetch_done;
    logic        rsp_due;
    logic        accept_now;
    logic        first_cycle;

    kind    = cases_mem[CaseWords*idx];
    addr    = cases_mem[CaseWords*idx+1];
    data    = cases_mem[CaseWords*idx+2];
    strb    = cases_mem[CaseWords*idx+3];
    exp_val = cases_mem[CaseWords*idx+4];
    exp_err = cases_mem[CaseWords*idx+5];
    if (kind == KindEoc) begin
      #1;
      check_value("eoc_o", eoc_o, exp_val);
      @(negedge clk_i);
    end else if (kind > KindEoc) begin
      errors++;
      $display("case %0d has an unknown operation kind %0d", idx, kind);
    end else begin
      bus_done        = (kind == KindFetch);
      fetch_done      = (kind == KindWrite) || (kind == KindRead);
      rsp_due         = 1'b0;
      first_cycle     = 1'b1;
      bus_valid_i     = !bus_done;
      bus_req_i.addr  = addr;
      bus_req_i.we    = (kind == KindWrite);
      bus_req_i.wdata = data;
      bus_req_i.strb  = strb[StrbWidth-1:0];
      fetch_valid_i   = !fetch_done;
      fetch_addr_i    = addr;
      while (!(bus_done && fetch_done)) begin
        // Sample between the falling and the rising edge
        #1;
        accept_now = bus_valid_i && bus_gnt_o;
        if (rsp_due) begin
          check_value("bus_rsp_valid_o", 32'(bus_rsp_valid_o), 32'd1);
          check_value("bus_rsp_o.rdata", bus_rsp_o.rdata, exp_val);
          check_value("bus_rsp_o.err", 32'(bus_rsp_o.err), exp_err);
          bus_done = 1'b1;
        end
        // Fetch owns the read port in its first cycle
        if (kind == KindContention && first_cycle) begin
          check_value("bus_gnt_o", 32'(bus_gnt_o), 32'd0);
        end
        if (kind == KindContention && accept_now) begin
          check_value("fetch_ready_o", 32'(fetch_ready_o || fetch_done), 32'd1);
        end
        if (fetch_valid_i && fetch_ready_o) begin
          check_value("fetch_data_o", fetch_data_o, exp_val);
          fetch_done = 1'b1;
        end
        first_cycle = 1'b0;
        @(negedge clk_i);
        if (accept_now) begin
          bus_valid_i = 1'b0;
        end
        if (fetch_done) begin
          fetch_valid_i = 1'b0;
        end
        rsp_due = accept_now;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin : main
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    bus_valid_i   = 1'b0;
    bus_req_i     = '0;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    errors        = 0;
    lfsr          = LfsrSeed;
    cases_loaded  = 1'b0;
    $readmemh("bench/fetch_bus_cases.txt", cases_mem);
    num_cases = 0;
    while (num_cases < MaxCases && cases_mem[CaseWords*num_cases] != KindEnd) begin
      num_cases++;
    end
    if (num_cases == 0 || num_cases == MaxCases) begin
      errors++;
      $display("cases file holds no operations or lacks its end line");
    end
    cases_loaded = 1'b1;
    repeat (ResetCycles) @(negedge clk_i);
    rst_i = 1'b0;
    #1;
    check_value("bus_rsp_valid_o", 32'(bus_rsp_valid_o), 32'd0);
    check_value("fetch_ready_o", 32'(fetch_ready_o), 32'd0);
    check_value("eoc_o", eoc_o, 32'd0);
    @(negedge clk_i);
    for (int c = 0; c < num_cases; c++) begin
      insert_idle_cycles();
      run_case(c);
    end
    $display("%0d errors in %0d cases", errors, num_cases);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    int limit_ns;
    wait (cases_loaded);
    limit_ns = (ResetCycles + CycleBudget * num_cases) * ClkPeriod;
    #(limit_ns);
    $display("timeout, the operations did not finish within %0d ns", limit_ns);
    $display("test failed");
    $finish;
  end

endmodule

// ==== bench/fetch_bus_cases.txt ====
// kind addr data strb expect err, all in hex
// kind 1 bus write, 2 bus read, 3 fetch, 4 fetch and bus read together, 5 eoc_o, 0 end
// Data memory, full word then bytes 0 and 2
1 00020010 deadbeef f 00000000 0
1 00020010 11223344 5 00000000 0
2 00020010 00000000 0 de22be44 0
// Instruction memory over the bus and over fetch
1 00010020 00500093 f 00000000 0
2 00010020 00000000 0 00500093 0
3 00010020 00000000 0 00500093 0
// Boot ROM table
3 00000000 00000000 0 000102b7 0
3 00000008 00000000 0 00030393 0
3 00000010 00000000 0 00000013 0
3 0000003c 00000000 0 0000006f 0
// CSRs
1 00030000 000000a5 f 00000000 0
5 00000000 00000000 0 000000a5 0
1 00030004 cafef00d f 00000000 0
2 00030004 00000000 0 cafef00d 0
1 00030008 12345678 f 00000000 0
2 00030008 00000000 0 c1057e01 0
2 0003000c 00000000 0 00000000 0
// Unmapped accesses leave the targets alone
1 00020000 5a5a0001 f 00000000 0
1 00000004 ffffffff f 00000000 1
1 00020400 ffffffff f 00000000 1
1 00030010 ffffffff f 00000000 1
2 00020000 00000000 0 5a5a0001 0
2 00030000 00000000 0 000000a5 0
2 00040000 00000000 0 00000000 1
// Contention on the instruction memory read port
1 00010040 00a00113 f 00000000 0
4 00010040 00000000 0 00a00113 0
4 00010020 00000000 0 00500093 0
0 00000000 00000000 0 00000000 0

// ==== tb.f ====
common/soc_addr_pkg.sv
common/soc_bus_pkg.sv
rtl/mem/instr_mem.sv
rtl/mem/data_mem.sv
rtl/cluster_csrs.sv
rtl/fetch_router.sv
rtl/bus_decoder.sv
rtl/cluster_top.sv
bench/tb_cluster_top.sv

// ==== run.sh ====
#!/bin/sh
# Compile the cluster testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_cluster_top \
  -f tb.f \
  -o sim_cluster

./obj_dir/sim_cluster > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
  exit 0
fi
exit 1
